/* mcu_pkg.sv */
// system level definitions for the mini mcu
// bus widths, memory map and slave selection

package mcu_pkg;

  // wishbone bus
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // address bits 31..28 pick the region, the rest is the offset seen by a slave
  localparam int OFFS_W   = 28;
  localparam int REGION_W = ADDR_W - OFFS_W;

  // word ram
  localparam int RAM_WORDS = 256;
  localparam int RAM_AW    = 8;

  // region base addresses
  localparam logic [ADDR_W-1:0] RAM_BASE  = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] GPIO_BASE = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] DMA_BASE  = 32'h3000_0000;

  // region ids as compared by the decoder
  localparam logic [REGION_W-1:0] RAM_REGION  = RAM_BASE[ADDR_W-1:OFFS_W];
  localparam logic [REGION_W-1:0] GPIO_REGION = GPIO_BASE[ADDR_W-1:OFFS_W];
  localparam logic [REGION_W-1:0] DMA_REGION  = DMA_BASE[ADDR_W-1:OFFS_W];

  // slave targets on the system bus
  typedef enum logic [1:0] {
    SEL_RAM,
    SEL_GPIO,
    SEL_DMA,
    SEL_NONE
  } slave_sel_t;

endpackage

/* periph_pkg.sv */
// peripheral definitions
// register offsets, gpio width and dma fsm states

package periph_pkg;

  // low offset bits decoded by the register slaves
  localparam int REG_AW = 8;

  localparam int GPIO_W = 8;

  // gpio register map
  localparam logic [REG_AW-1:0] GPIO_OUT = 8'h00;
  localparam logic [REG_AW-1:0] GPIO_OE  = 8'h04;
  localparam logic [REG_AW-1:0] GPIO_IN  = 8'h08;
  localparam logic [REG_AW-1:0] GPIO_IE  = 8'h0C;
  localparam logic [REG_AW-1:0] GPIO_IS  = 8'h10;

  // dma register map
  localparam logic [REG_AW-1:0] DMA_SRC  = 8'h00;
  localparam logic [REG_AW-1:0] DMA_DST  = 8'h04;
  localparam logic [REG_AW-1:0] DMA_LEN  = 8'h08;
  localparam logic [REG_AW-1:0] DMA_CTRL = 8'h0C;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_READ,
    DMA_WRITE
  } dma_state_t;

endpackage

/* bus_arbiter.sv */
// system bus arbiter for the host and dma masters
// round-robin grant, region decode, response routing

`timescale 1ns/1ps

module bus_arbiter (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // host master
  input  logic                        m0_cyc_i,
  input  logic                        m0_stb_i,
  input  logic                        m0_we_i,
  input  logic [mcu_pkg::ADDR_W-1:0]  m0_adr_i,
  input  logic [mcu_pkg::DATA_W-1:0]  m0_dat_i,
  output logic [mcu_pkg::DATA_W-1:0]  m0_dat_o,
  output logic                        m0_ack_o,
  // dma master
  input  logic                        m1_cyc_i,
  input  logic                        m1_stb_i,
  input  logic                        m1_we_i,
  input  logic [mcu_pkg::ADDR_W-1:0]  m1_adr_i,
  input  logic [mcu_pkg::DATA_W-1:0]  m1_dat_i,
  output logic [mcu_pkg::DATA_W-1:0]  m1_dat_o,
  output logic                        m1_ack_o,
  // shared slave request
  output logic                        s_we_o,
  output logic [mcu_pkg::OFFS_W-1:0]  s_adr_o,
  output logic [mcu_pkg::DATA_W-1:0]  s_dat_o,
  // per slave strobe and response
  output logic                        ram_stb_o,
  input  logic                        ram_ack_i,
  input  logic [mcu_pkg::DATA_W-1:0]  ram_dat_i,
  output logic                        gpio_stb_o,
  input  logic                        gpio_ack_i,
  input  logic [mcu_pkg::DATA_W-1:0]  gpio_dat_i,
  output logic                        dma_stb_o,
  input  logic                        dma_ack_i,
  input  logic [mcu_pkg::DATA_W-1:0]  dma_dat_i
);

  logic                        gnt_valid_q;
  logic                        gnt_idx_q;
  logic                        last_q;
  logic                        pick;
  logic                        none_ack_q;
  logic                        g_cyc;
  logic                        g_stb;
  logic                        g_we;
  logic [mcu_pkg::ADDR_W-1:0]  g_adr;
  logic [mcu_pkg::DATA_W-1:0]  g_dat;
  logic                        bus_stb;
  logic [mcu_pkg::REGION_W-1:0] region;
  mcu_pkg::slave_sel_t         sel;
  logic                        resp_ack;
  logic [mcu_pkg::DATA_W-1:0]  resp_dat;

  // on contention the master not served last wins
  assign pick = (m0_cyc_i && m1_cyc_i) ? ~last_q : m1_cyc_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gnt_valid_q <= 1'b0;
      gnt_idx_q   <= 1'b0;
      last_q      <= 1'b1;
    end else if (gnt_valid_q) begin
      if (!g_cyc) begin
        gnt_valid_q <= 1'b0;
      end
    end else if (m0_cyc_i || m1_cyc_i) begin
      gnt_valid_q <= 1'b1;
      gnt_idx_q   <= pick;
      last_q      <= pick;
    end
  end

  // request of the granted master
  assign g_cyc = gnt_idx_q ? m1_cyc_i : m0_cyc_i;
  assign g_stb = gnt_idx_q ? m1_stb_i : m0_stb_i;
  assign g_we  = gnt_idx_q ? m1_we_i : m0_we_i;
  assign g_adr = gnt_idx_q ? m1_adr_i : m0_adr_i;
  assign g_dat = gnt_idx_q ? m1_dat_i : m0_dat_i;

  assign bus_stb = gnt_valid_q && g_cyc && g_stb;
  assign region  = g_adr[mcu_pkg::ADDR_W-1:mcu_pkg::OFFS_W];

  always_comb begin
    if (region == mcu_pkg::RAM_REGION) begin
      sel = mcu_pkg::SEL_RAM;
    end else if (region == mcu_pkg::GPIO_REGION) begin
      sel = mcu_pkg::SEL_GPIO;
    end else if (region == mcu_pkg::DMA_REGION) begin
      sel = mcu_pkg::SEL_DMA;
    end else begin
      sel = mcu_pkg::SEL_NONE;
    end
  end

  assign s_we_o     = g_we;
  assign s_adr_o    = g_adr[mcu_pkg::OFFS_W-1:0];
  assign s_dat_o    = g_dat;
  assign ram_stb_o  = bus_stb && (sel == mcu_pkg::SEL_RAM);
  assign gpio_stb_o = bus_stb && (sel == mcu_pkg::SEL_GPIO);
  assign dma_stb_o  = bus_stb && (sel == mcu_pkg::SEL_DMA);

  // unmapped space is acked here, reads as zero
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      none_ack_q <= 1'b0;
    end else begin
      none_ack_q <= bus_stb && (sel == mcu_pkg::SEL_NONE) && !none_ack_q;
    end
  end

  always_comb begin
    case (sel)
      mcu_pkg::SEL_RAM: begin
        resp_ack = ram_ack_i;
        resp_dat = ram_dat_i;
      end
      mcu_pkg::SEL_GPIO: begin
        resp_ack = gpio_ack_i;
        resp_dat = gpio_dat_i;
      end
      mcu_pkg::SEL_DMA: begin
        resp_ack = dma_ack_i;
        resp_dat = dma_dat_i;
      end
      default: begin
        resp_ack = none_ack_q;
        resp_dat = '0;
      end
    endcase
  end

  assign m0_ack_o = bus_stb && !gnt_idx_q && resp_ack;
  assign m1_ack_o = bus_stb && gnt_idx_q && resp_ack;
  assign m0_dat_o = (gnt_valid_q && !gnt_idx_q) ? resp_dat : '0;
  assign m1_dat_o = (gnt_valid_q && gnt_idx_q) ? resp_dat : '0;

endmodule

/* sram_bank.sv */
// single bank word ram on the system bus
// registered read data and one-cycle ack

`timescale 1ns/1ps

module sram_bank (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic [mcu_pkg::RAM_AW-1:0]  adr_i,
  input  logic [mcu_pkg::DATA_W-1:0]  dat_i,
  output logic [mcu_pkg::DATA_W-1:0]  dat_o,
  output logic                        ack_o
);

  logic [mcu_pkg::DATA_W-1:0] mem [mcu_pkg::RAM_WORDS];
  logic                       access;

  // act once, on the first strobe cycle
  assign access = stb_i && !ack_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (we_i) begin
        mem[adr_i] <= dat_i;
      end
      dat_o <= mem[adr_i];
    end
  end

endmodule

/* gpio_block.sv */
// 8-pin gpio with output enable and rising edge interrupts
// inputs pass a two flop synchronizer before edge detection

`timescale 1ns/1ps

module gpio_block (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           stb_i,
  input  logic                           we_i,
  input  logic [periph_pkg::REG_AW-1:0]  adr_i,
  input  logic [mcu_pkg::DATA_W-1:0]     dat_i,
  input  logic [periph_pkg::GPIO_W-1:0]  gpio_i,
  output logic [mcu_pkg::DATA_W-1:0]     dat_o,
  output logic                           ack_o,
  output logic [periph_pkg::GPIO_W-1:0]  gpio_o,
  output logic [periph_pkg::GPIO_W-1:0]  gpio_oe_o,
  output logic                           gpio_irq_o
);

  logic [periph_pkg::GPIO_W-1:0] out_q;
  logic [periph_pkg::GPIO_W-1:0] oe_q;
  logic [periph_pkg::GPIO_W-1:0] ie_q;
  logic [periph_pkg::GPIO_W-1:0] is_q;
  logic [periph_pkg::GPIO_W-1:0] sync1_q;
  logic [periph_pkg::GPIO_W-1:0] sync2_q;
  logic [periph_pkg::GPIO_W-1:0] prev_q;
  logic [periph_pkg::GPIO_W-1:0] rise;
  logic [periph_pkg::GPIO_W-1:0] is_clr;
  logic [periph_pkg::GPIO_W-1:0] rd_val;
  logic                          access;
  logic                          wr;

  assign access = stb_i && !ack_o;
  assign wr     = access && we_i;
  assign rise   = sync2_q & ~prev_q;

  // write one to clear
  assign is_clr = (wr && adr_i == periph_pkg::GPIO_IS) ? dat_i[periph_pkg::GPIO_W-1:0] : '0;

  always_comb begin
    case (adr_i)
      periph_pkg::GPIO_OUT: rd_val = out_q;
      periph_pkg::GPIO_OE:  rd_val = oe_q;
      periph_pkg::GPIO_IN:  rd_val = sync2_q;
      periph_pkg::GPIO_IE:  rd_val = ie_q;
      periph_pkg::GPIO_IS:  rd_val = is_q;
      default:              rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q   <= '0;
      oe_q    <= '0;
      ie_q    <= '0;
      is_q    <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      ack_o   <= 1'b0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      ack_o   <= access;
      // a new edge wins over a clear in the same cycle
      is_q    <= (is_q & ~is_clr) | (rise & ie_q);
      if (wr && adr_i == periph_pkg::GPIO_OUT) begin
        out_q <= dat_i[periph_pkg::GPIO_W-1:0];
      end
      if (wr && adr_i == periph_pkg::GPIO_OE) begin
        oe_q <= dat_i[periph_pkg::GPIO_W-1:0];
      end
      if (wr && adr_i == periph_pkg::GPIO_IE) begin
        ie_q <= dat_i[periph_pkg::GPIO_W-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_o <= {{(mcu_pkg::DATA_W - periph_pkg::GPIO_W){1'b0}}, rd_val};
    end
  end

  assign gpio_o     = out_q;
  assign gpio_oe_o  = oe_q;
  assign gpio_irq_o = |is_q;

endmodule

/* dma_engine.sv */
// single channel dma, word copy from src to dst
// register slave for setup and a wishbone master for the copy

`timescale 1ns/1ps

module dma_engine (
  input  logic                           clk_i,
  input  logic                           reset_i,
  // register slave
  input  logic                           stb_i,
  input  logic                           we_i,
  input  logic [periph_pkg::REG_AW-1:0]  adr_i,
  input  logic [mcu_pkg::DATA_W-1:0]     dat_i,
  output logic [mcu_pkg::DATA_W-1:0]     dat_o,
  output logic                           ack_o,
  // copy master
  output logic                           mst_cyc_o,
  output logic                           mst_stb_o,
  output logic                           mst_we_o,
  output logic [mcu_pkg::ADDR_W-1:0]     mst_adr_o,
  output logic [mcu_pkg::DATA_W-1:0]     mst_dat_o,
  input  logic [mcu_pkg::DATA_W-1:0]     mst_dat_i,
  input  logic                           mst_ack_i,
  output logic                           dma_done_o
);

  periph_pkg::dma_state_t     state_q;
  logic [mcu_pkg::DATA_W-1:0] src_q;
  logic [mcu_pkg::DATA_W-1:0] dst_q;
  logic [mcu_pkg::DATA_W-1:0] len_q;
  logic [mcu_pkg::ADDR_W-1:0] rd_adr_q;
  logic [mcu_pkg::ADDR_W-1:0] wr_adr_q;
  logic [mcu_pkg::DATA_W-1:0] remain_q;
  logic [mcu_pkg::DATA_W-1:0] buf_q;
  logic [mcu_pkg::DATA_W-1:0] rd_val;
  logic                       req_q;
  logic                       done_q;
  logic                       busy;
  logic                       access;
  logic                       wr;
  logic                       start;

  assign busy   = (state_q != periph_pkg::DMA_IDLE);
  assign access = stb_i && !ack_o;
  assign wr     = access && we_i;
  assign start  = wr && adr_i == periph_pkg::DMA_CTRL && dat_i[0] && !busy && len_q != '0;

  always_comb begin
    case (adr_i)
      periph_pkg::DMA_SRC:  rd_val = src_q;
      periph_pkg::DMA_DST:  rd_val = dst_q;
      periph_pkg::DMA_LEN:  rd_val = len_q;
      periph_pkg::DMA_CTRL: rd_val = {{(mcu_pkg::DATA_W - 2){1'b0}}, done_q, busy};
      default:              rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_q    <= '0;
      dst_q    <= '0;
      len_q    <= '0;
      ack_o    <= 1'b0;
      state_q  <= periph_pkg::DMA_IDLE;
      req_q    <= 1'b0;
      done_q   <= 1'b0;
      rd_adr_q <= '0;
      wr_adr_q <= '0;
      remain_q <= '0;
    end else begin
      ack_o <= access;
      if (wr && adr_i == periph_pkg::DMA_SRC) src_q <= dat_i;
      if (wr && adr_i == periph_pkg::DMA_DST) dst_q <= dat_i;
      if (wr && adr_i == periph_pkg::DMA_LEN) len_q <= dat_i;
      case (state_q)
        periph_pkg::DMA_IDLE: begin
          if (start) begin
            rd_adr_q <= src_q;
            wr_adr_q <= dst_q;
            remain_q <= len_q;
            done_q   <= 1'b0;
            state_q  <= periph_pkg::DMA_READ;
          end
        end
        periph_pkg::DMA_READ: begin
          if (!req_q) begin
            req_q <= 1'b1;
          end else if (mst_ack_i) begin
            req_q    <= 1'b0;
            rd_adr_q <= rd_adr_q + 32'd4;
            state_q  <= periph_pkg::DMA_WRITE;
          end
        end
        periph_pkg::DMA_WRITE: begin
          if (!req_q) begin
            req_q <= 1'b1;
          end else if (mst_ack_i) begin
            req_q    <= 1'b0;
            wr_adr_q <= wr_adr_q + 32'd4;
            remain_q <= remain_q - 1'b1;
            // last word moved
            if (remain_q == 1) begin
              done_q  <= 1'b1;
              state_q <= periph_pkg::DMA_IDLE;
            end else begin
              state_q <= periph_pkg::DMA_READ;
            end
          end
        end
        default: state_q <= periph_pkg::DMA_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_o <= rd_val;
    end
    if (state_q == periph_pkg::DMA_READ && req_q && mst_ack_i) begin
      buf_q <= mst_dat_i;
    end
  end

  assign mst_cyc_o  = req_q;
  assign mst_stb_o  = req_q;
  assign mst_we_o   = (state_q == periph_pkg::DMA_WRITE);
  assign mst_adr_o  = (state_q == periph_pkg::DMA_WRITE) ? wr_adr_q : rd_adr_q;
  assign mst_dat_o  = buf_q;
  assign dma_done_o = done_q;

endmodule

/* mini_mcu.sv */
// mini mcu top level
// host and dma masters share one bus to ram, gpio and dma registers

`timescale 1ns/1ps

module mini_mcu (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           host_cyc_i,
  input  logic                           host_stb_i,
  input  logic                           host_we_i,
  input  logic [mcu_pkg::ADDR_W-1:0]     host_adr_i,
  input  logic [mcu_pkg::DATA_W-1:0]     host_dat_i,
  output logic [mcu_pkg::DATA_W-1:0]     host_dat_o,
  output logic                           host_ack_o,
  input  logic [periph_pkg::GPIO_W-1:0]  gpio_i,
  output logic [periph_pkg::GPIO_W-1:0]  gpio_o,
  output logic [periph_pkg::GPIO_W-1:0]  gpio_oe_o,
  output logic                           gpio_irq_o,
  output logic                           dma_done_o
);

  // dma master side
  logic                       dma_cyc;
  logic                       dma_stb;
  logic                       dma_we;
  logic [mcu_pkg::ADDR_W-1:0] dma_adr;
  logic [mcu_pkg::DATA_W-1:0] dma_wdat;
  logic [mcu_pkg::DATA_W-1:0] dma_rdat;
  logic                       dma_ack;

  // shared slave request
  logic                       s_we;
  logic [mcu_pkg::OFFS_W-1:0] s_adr;
  logic [mcu_pkg::DATA_W-1:0] s_dat;

  // slave strobes and responses
  logic                       ram_stb;
  logic                       ram_ack;
  logic [mcu_pkg::DATA_W-1:0] ram_dat;
  logic                       gpio_stb;
  logic                       gpio_ack;
  logic [mcu_pkg::DATA_W-1:0] gpio_dat;
  logic                       dreg_stb;
  logic                       dreg_ack;
  logic [mcu_pkg::DATA_W-1:0] dreg_dat;

  bus_arbiter bus_arbiter_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .m0_cyc_i   (host_cyc_i),
    .m0_stb_i   (host_stb_i),
    .m0_we_i    (host_we_i),
    .m0_adr_i   (host_adr_i),
    .m0_dat_i   (host_dat_i),
    .m0_dat_o   (host_dat_o),
    .m0_ack_o   (host_ack_o),
    .m1_cyc_i   (dma_cyc),
    .m1_stb_i   (dma_stb),
    .m1_we_i    (dma_we),
    .m1_adr_i   (dma_adr),
    .m1_dat_i   (dma_wdat),
    .m1_dat_o   (dma_rdat),
    .m1_ack_o   (dma_ack),
    .s_we_o     (s_we),
    .s_adr_o    (s_adr),
    .s_dat_o    (s_dat),
    .ram_stb_o  (ram_stb),
    .ram_ack_i  (ram_ack),
    .ram_dat_i  (ram_dat),
    .gpio_stb_o (gpio_stb),
    .gpio_ack_i (gpio_ack),
    .gpio_dat_i (gpio_dat),
    .dma_stb_o  (dreg_stb),
    .dma_ack_i  (dreg_ack),
    .dma_dat_i  (dreg_dat)
  );

  // ram takes the word index out of the byte offset
  sram_bank sram_bank_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .stb_i   (ram_stb),
    .we_i    (s_we),
    .adr_i   (s_adr[mcu_pkg::RAM_AW+1:2]),
    .dat_i   (s_dat),
    .dat_o   (ram_dat),
    .ack_o   (ram_ack)
  );

  gpio_block gpio_block_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .stb_i      (gpio_stb),
    .we_i       (s_we),
    .adr_i      (s_adr[periph_pkg::REG_AW-1:0]),
    .dat_i      (s_dat),
    .gpio_i     (gpio_i),
    .dat_o      (gpio_dat),
    .ack_o      (gpio_ack),
    .gpio_o     (gpio_o),
    .gpio_oe_o  (gpio_oe_o),
    .gpio_irq_o (gpio_irq_o)
  );

  dma_engine dma_engine_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .stb_i      (dreg_stb),
    .we_i       (s_we),
    .adr_i      (s_adr[periph_pkg::REG_AW-1:0]),
    .dat_i      (s_dat),
    .dat_o      (dreg_dat),
    .ack_o      (dreg_ack),
    .mst_cyc_o  (dma_cyc),
    .mst_stb_o  (dma_stb),
    .mst_we_o   (dma_we),
    .mst_adr_o  (dma_adr),
    .mst_dat_o  (dma_wdat),
    .mst_dat_i  (dma_rdat),
    .mst_ack_i  (dma_ack),
    .dma_done_o (dma_done_o)
  );

endmodule

/* tb_mini_mcu_assert.sv */
// bus protocol checks for the mini mcu
// bound into the top level next to the arbiter

`timescale 1ns/1ps

module tb_mini_mcu_assert (
  input logic                           clk_i,
  input logic                           reset_i,
  input logic                           host_cyc_i,
  input logic                           host_stb_i,
  input logic                           host_ack_i,
  input logic                           dma_cyc_i,
  input logic                           dma_stb_i,
  input logic                           dma_ack_i,
  input logic [periph_pkg::GPIO_W-1:0]  gpio_oe_i
);

  // a grant handover needs idle cycles, so acks never touch across masters
  ack_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(host_ack_i && (dma_ack_i || $past(dma_ack_i))) && !(dma_ack_i && $past(host_ack_i)))
    else $error("host and dma acked in the same or adjacent cycles");

  // ack only goes to a master that has held its request since the cycle before
  host_ack_owner: assert property (@(posedge clk_i) disable iff (reset_i)
    host_ack_i |-> (host_cyc_i && host_stb_i && $past(host_cyc_i && host_stb_i)))
    else $error("host ack without host cyc and stb held");

  dma_ack_owner: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_ack_i |-> (dma_cyc_i && dma_stb_i && $past(dma_cyc_i && dma_stb_i)))
    else $error("dma ack without dma cyc and stb held");

  host_ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
    host_ack_i |=> !host_ack_i)
    else $error("host ack longer than one cycle");

  dma_ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_ack_i |=> !dma_ack_i)
    else $error("dma ack longer than one cycle");

  oe_after_reset: assert property (@(posedge clk_i)
    $fell(reset_i) |-> (gpio_oe_i == '0))
    else $error("gpio output enable not cleared by reset");

endmodule

bind mini_mcu tb_mini_mcu_assert tb_mini_mcu_assert_inst (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .host_cyc_i (host_cyc_i),
  .host_stb_i (host_stb_i),
  .host_ack_i (host_ack_o),
  .dma_cyc_i  (dma_cyc),
  .dma_stb_i  (dma_stb),
  .dma_ack_i  (dma_ack),
  .gpio_oe_i  (gpio_oe_o)
);

/* tb_mini_mcu.sv */
// testbench for the mini mcu
// random host traffic checked against a model of ram, gpio and dma

`timescale 1ns/1ps

module tb_mini_mcu;

  localparam int CLK_HALF     = 50;
  localparam int RESET_CYCLES = 8;
  localparam int N_RAM        = 24;
  localparam int N_GPIO       = 8;
  localparam int N_IRQ        = 8;
  localparam int SRC_WORD     = 64;
  localparam int DST_WORD     = 128;
  // upper bounds for the watchdog
  localparam int MAX_ACCESSES  = 220;
  localparam int ACCESS_CYCLES = 12;
  localparam int DMA_CYCLES    = 16 * 2 * ACCESS_CYCLES;
  localparam int RUN_CYCLES    = RESET_CYCLES + MAX_ACCESSES * ACCESS_CYCLES + DMA_CYCLES;

  logic                           clk_i;
  logic                           reset_i;
  logic                           host_cyc_i;
  logic                           host_stb_i;
  logic                           host_we_i;
  logic [mcu_pkg::ADDR_W-1:0]     host_adr_i;
  logic [mcu_pkg::DATA_W-1:0]     host_dat_i;
  logic [mcu_pkg::DATA_W-1:0]     host_dat_o;
  logic                           host_ack_o;
  logic [periph_pkg::GPIO_W-1:0]  gpio_i;
  logic [periph_pkg::GPIO_W-1:0]  gpio_o;
  logic [periph_pkg::GPIO_W-1:0]  gpio_oe_o;
  logic                           gpio_irq_o;
  logic                           dma_done_o;

  logic [31:0] ram_model [mcu_pkg::RAM_WORDS];
  bit          ram_written [mcu_pkg::RAM_WORDS];
  int          seed;
  int          checks;
  int          errors;

  mini_mcu mini_mcu_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  function automatic int rand_range(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  // one wishbone classic cycle on the host port, returns at the ack edge
  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
    @(posedge clk_i);
    host_cyc_i <= 1'b1;
    host_stb_i <= 1'b1;
    host_we_i  <= we;
    host_adr_i <= adr;
    host_dat_i <= wdat;
    do begin
      @(posedge clk_i);
    end while (!host_ack_o);
    rdat = host_dat_o;
    host_cyc_i <= 1'b0;
    host_stb_i <= 1'b0;
    host_we_i  <= 1'b0;
  endtask

  task automatic reg_write(input logic [31:0] adr, input logic [31:0] val);
    logic [31:0] ignored;
    bus_access(1'b1, adr, val, ignored);
  endtask

  task automatic reg_read(input logic [31:0] adr, output logic [31:0] val);
    bus_access(1'b0, adr, '0, val);
  endtask

  task automatic ram_write(input int idx, input logic [31:0] val);
    reg_write(mcu_pkg::RAM_BASE + 32'(idx * 4), val);
    ram_model[idx]   = val;
    ram_written[idx] = 1'b1;
  endtask

  task automatic ram_read_check(input int idx);
    logic [31:0] rdat;
    reg_read(mcu_pkg::RAM_BASE + 32'(idx * 4), rdat);
    check_value("host_dat_o", ram_model[idx], rdat);
  endtask

  initial begin
    int          idx_list [N_RAM];
    int          idx;
    int          len;
    int          pin;
    logic [31:0] rdat;
    logic [31:0] val;
    logic [7:0]  pins;
    logic [7:0]  ie;
    logic [7:0]  exp_is;

    seed       = 87078;
    checks     = 0;
    errors     = 0;
    reset_i    = 1'b1;
    host_cyc_i = 1'b0;
    host_stb_i = 1'b0;
    host_we_i  = 1'b0;
    host_adr_i = '0;
    host_dat_i = '0;
    gpio_i     = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);

    // reset state
    check_value("host_ack_o", 32'h0, 32'(host_ack_o));
    check_value("gpio_oe_o", 32'h0, 32'(gpio_oe_o));
    check_value("gpio_o", 32'h0, 32'(gpio_o));
    check_value("gpio_irq_o", 32'h0, 32'(gpio_irq_o));
    check_value("dma_done_o", 32'h0, 32'(dma_done_o));

    // ram write then read back, plus an unmapped read
    for (int i = 0; i < N_RAM; i++) begin
      idx_list[i] = rand_range(mcu_pkg::RAM_WORDS);
      ram_write(idx_list[i], $random(seed));
    end
    for (int i = 0; i < N_RAM; i++) begin
      ram_read_check(idx_list[i]);
    end
    reg_read(32'h5000_0000 | (32'($random(seed)) & 32'h0FFF_FFFC), rdat);
    check_value("host_dat_o", 32'h0, rdat);

    // gpio outputs and synchronized inputs
    for (int i = 0; i < N_GPIO; i++) begin
      val = $random(seed);
      reg_write(mcu_pkg::GPIO_BASE + periph_pkg::GPIO_OUT, val);
      check_value("gpio_o", 32'(val[7:0]), 32'(gpio_o));
      val = $random(seed);
      reg_write(mcu_pkg::GPIO_BASE + periph_pkg::GPIO_OE, val);
      check_value("gpio_oe_o", 32'(val[7:0]), 32'(gpio_oe_o));
      pins = 8'(rand_range(256));
      gpio_i <= pins;
      wait_cycles(4);
      reg_read(mcu_pkg::GPIO_BASE + periph_pkg::GPIO_IN, rdat);
      check_value("host_dat_o", 32'(pins), rdat);
    end

    // rising edge interrupts on enabled pins
    gpio_i <= '0;
    wait_cycles(4);
    ie = 8'(rand_range(256));
    reg_write(mcu_pkg::GPIO_BASE + periph_pkg::GPIO_IE, 32'(ie));
    for (int i = 0; i < N_IRQ; i++) begin
      pin = rand_range(periph_pkg::GPIO_W);
      gpio_i <= 8'h1 << pin;
      wait_cycles(5);
      exp_is = ie & (8'h1 << pin);
      check_value("gpio_irq_o", 32'(exp_is != 0), 32'(gpio_irq_o));
      reg_read(mcu_pkg::GPIO_BASE + periph_pkg::GPIO_IS, rdat);
      check_value("host_dat_o", 32'(exp_is), rdat);
      if (exp_is != 0) begin
        reg_write(mcu_pkg::GPIO_BASE + periph_pkg::GPIO_IS, 32'(exp_is));
        wait_cycles(1);
        check_value("gpio_irq_o", 32'h0, 32'(gpio_irq_o));
      end
      gpio_i <= '0;
      wait_cycles(4);
    end

    // dma copy with host traffic outside both areas
    len = 1 + rand_range(16);
    for (int i = 0; i < len; i++) begin
      ram_write(SRC_WORD + i, $random(seed));
    end
    reg_write(mcu_pkg::DMA_BASE + periph_pkg::DMA_SRC, mcu_pkg::RAM_BASE + SRC_WORD * 4);
    reg_write(mcu_pkg::DMA_BASE + periph_pkg::DMA_DST, mcu_pkg::RAM_BASE + DST_WORD * 4);
    reg_write(mcu_pkg::DMA_BASE + periph_pkg::DMA_LEN, 32'(len));
    reg_write(mcu_pkg::DMA_BASE + periph_pkg::DMA_CTRL, 32'h1);
    while (!dma_done_o) begin
      idx = rand_range(128);
      if (idx >= 64) begin
        idx = idx + 128;
      end
      if (rand_range(2) == 0 || !ram_written[idx]) begin
        ram_write(idx, $random(seed));
      end else begin
        ram_read_check(idx);
      end
    end
    for (int i = 0; i < len; i++) begin
      ram_model[DST_WORD + i]   = ram_model[SRC_WORD + i];
      ram_written[DST_WORD + i] = 1'b1;
      ram_read_check(DST_WORD + i);
    end
    // done set, busy clear
    reg_read(mcu_pkg::DMA_BASE + periph_pkg::DMA_CTRL, rdat);
    check_value("host_dat_o", 32'h2, rdat);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    repeat (RUN_CYCLES) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", RUN_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* mini_mcu.f */
mcu_pkg.sv
periph_pkg.sv
bus_arbiter.sv
sram_bank.sv
gpio_block.sv
dma_engine.sv
mini_mcu.sv
tb_mini_mcu_assert.sv
tb_mini_mcu.sv

/* run_sim.sh */
#!/bin/sh
# build the mini mcu testbench with verilator, run it, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mini_mcu \
  -f mini_mcu.f -o sim_mini_mcu \
  && ./obj_dir/sim_mini_mcu | tee sim.log
grep -q "^Done: no errors$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
